/* icache_top.f */
verilog/mem_bus_pkg.sv
verilog/cache_geom_pkg.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
verif/icache_tb.sv

/* verif/icache_stim.txt */
// one access per line in hex: address_latency_hit_word
// latency 0 draws a random memory delay, word is address xor a5c3
0010_3_0_A5D3
0011_0_1_A5D2
0012_0_1_A5D1
0013_0_1_A5D0
0010_0_1_A5D3
0024_2_0_A5E7
0027_0_1_A5E4
0110_5_0_A4D3
0112_0_1_A4D1
0011_0_1_A5D2
0211_0_0_A7D2
0013_0_1_A5D0
0110_4_0_A4D3
0212_1_0_A7D1
0111_0_1_A4D2
0010_0_0_A5D3
0113_0_1_A4D0
0026_0_1_A5E5
003C_6_0_A5FF
003D_0_1_A5FE
013C_0_0_A4FF
003E_0_1_A5FD
013F_0_1_A4FC
0028_2_0_A5EB
0029_0_1_A5EA
0012_0_1_A5D1

/* verif/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ENTRIES = 26;
    // reset plus up to 30 accesses of about 10 cycles each and a margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 30 * 10 + 50;
    localparam word_t LINE_PATTERN = 16'hA5C3;

    logic   clk;
    logic   reset_n;
    logic   cpu_valid;
    word_t  cpu_addr;
    word_t  cpu_data;
    logic   cpu_ready;
    logic   mem_read;
    word_t  mem_addr;
    line_t  mem_line;
    logic   mem_ready;
    count_t hit_count;
    count_t access_count;

    // addr [39:24], latency [23:20], hit [19:16], word [15:0]
    logic [39:0] stim [NUM_ENTRIES];

    int     error_count;
    int     cycle_count;
    int     cur_latency;
    integer seed;

    icache_top DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_valid    (cpu_valid),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data),
        .cpu_ready    (cpu_ready),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_line     (mem_line),
        .mem_ready    (mem_ready),
        .hit_count    (hit_count),
        .access_count (access_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // each word of a line is its own address xor the pattern
    function automatic line_t build_line(input word_t line_addr);
        line_t line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i*WORD_BITS +: WORD_BITS] = (line_addr + word_t'(i)) ^ LINE_PATTERN;
        end
        return line;
    endfunction

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // memory answers after cur_latency falling clock edges with mem_read high
    initial begin : memory_model
        int waited;
        waited = 0;
        mem_ready = 1'b0;
        mem_line = '0;
        forever begin
            @(negedge clk);
            mem_ready = 1'b0;
            if (mem_read) begin
                waited = waited + 1;
                if (waited >= cur_latency) begin
                    mem_line = build_line(mem_addr);
                    mem_ready = 1'b1;
                    waited = 0;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the cache did not finish all accesses in %0d cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        logic [39:0] entry;
        word_t addr;
        logic  exp_hit;
        word_t exp_word;
        int    exp_hits;
        logic  saw_read;
        word_t read_addr;
        word_t got_word;

        error_count = 0;
        exp_hits = 0;
        seed = 36;
        cur_latency = 1;
        reset_n = 1'b0;
        cpu_valid = 1'b0;
        cpu_addr = '0;
        $readmemh("verif/icache_stim.txt", stim);

        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;

        // idle cache right after reset
        repeat (2) begin
            @(posedge clk);
            check_value(0, cpu_ready, "cpu_ready after reset");
            check_value(0, mem_read, "mem_read after reset");
            check_value(0, access_count, "access_count after reset");
            check_value(0, hit_count, "hit_count after reset");
        end

        for (int n = 0; n < NUM_ENTRIES; n++) begin
            entry = stim[n];
            addr = entry[39:24];
            exp_hit = entry[16];
            exp_word = entry[15:0];
            if (exp_hit) begin
                exp_hits++;
            end
            @(negedge clk);
            if (entry[23:20] == 4'd0) begin
                cur_latency = ($random(seed) & 3) + 1;
            end else begin
                cur_latency = entry[23:20];
            end
            cpu_valid = 1'b1;
            cpu_addr = addr;
            saw_read = 1'b0;
            read_addr = '0;
            // request held until cpu_ready
            do begin
                @(posedge clk);
                if (mem_read) begin
                    saw_read = 1'b1;
                    read_addr = mem_addr;
                end
            end while (!cpu_ready);
            got_word = cpu_data;

            if (exp_hit && saw_read) begin
                error_count++;
                $display("access %0d to %h should hit, but the cache read memory", n, addr);
            end else if (!exp_hit && !saw_read) begin
                error_count++;
                $display("access %0d to %h should miss, but mem_read never rose", n, addr);
            end
            if (saw_read) begin
                check_value(addr & 16'hFFFC, read_addr, "mem_addr");
            end
            check_value(exp_word, got_word, "cpu_data");
            @(negedge clk);
            cpu_valid = 1'b0;
        end

        @(negedge clk);
        check_value(NUM_ENTRIES, access_count, "access_count");
        check_value(exp_hits, hit_count, "hit_count");
        $display("accesses %0d, expected hits %0d, errors %0d", NUM_ENTRIES, exp_hits,
                 error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/cache_geom_pkg.sv */
package cache_geom_pkg;

    import mem_bus_pkg::*;

    // two ways per set
    localparam int NUM_SETS = 4;

    // address split into tag, index and offset from the top down
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = WORD_BITS - INDEX_BITS - OFFSET_BITS;

    // statistics width
    localparam int COUNT_BITS = 16;

    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [COUNT_BITS-1:0] count_t;

endpackage

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,

    // cpu fetch port
    input  logic   cpu_valid,
    input  word_t  cpu_addr,
    output word_t  cpu_data,
    output logic   cpu_ready,

    // memory line port
    output logic   mem_read,
    output word_t  mem_addr,
    input  line_t  mem_line,
    input  logic   mem_ready,

    // tag store
    input  logic   hit_way1,
    input  logic   hit_way2,
    input  logic   victim_way2,
    output logic   touch,
    output logic   fill,
    output logic   fill_way2,

    // data store
    input  word_t  word_way1,
    input  word_t  word_way2,

    // statistics
    output count_t hit_count,
    output count_t access_count
);

    typedef enum logic {
        CHECK,
        ALLOCATE
    } state_t;

    state_t state;
    state_t next_state;

    logic    hit;
    logic    hit_resp;
    logic    miss;
    offset_t cpu_offset;
    word_t   fill_word;
    word_t   hit_word;

    assign cpu_offset = cpu_addr[OFFSET_BITS-1:0];
    assign hit        = hit_way1 || hit_way2;

    // hit answers in the lookup cycle
    assign hit_resp = (state == CHECK) && cpu_valid && hit;
    assign miss     = (state == CHECK) && cpu_valid && !hit;

    // line arrives, goes into the store and straight to the cpu
    assign fill  = (state == ALLOCATE) && mem_ready;
    assign touch = hit_resp;

    assign fill_word = mem_line[cpu_offset*WORD_BITS +: WORD_BITS];
    assign hit_word  = hit_way1 ? word_way1 : word_way2;

    assign cpu_ready = hit_resp || fill;
    assign cpu_data  = fill ? fill_word : hit_word;

    always_comb begin
        next_state = state;
        case (state)
            CHECK: begin
                if (miss) begin
                    next_state = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_ready) begin
                    next_state = CHECK;
                end
            end
            default: begin
                next_state = CHECK;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= CHECK;
            mem_read <= 1'b0;
        end else begin
            state <= next_state;
            if (miss) begin
                mem_read <= 1'b1;
            end else if (fill) begin
                mem_read <= 1'b0;
            end
        end
    end

    // request address and victim are held for the whole miss
    always_ff @(posedge clk) begin
        if (miss) begin
            mem_addr  <= {cpu_addr[WORD_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            fill_way2 <= victim_way2;
        end
    end

    // one access per cpu_ready pulse
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            access_count <= '0;
            hit_count    <= '0;
        end else begin
            if (cpu_ready) begin
                access_count <= access_count + 1'b1;
            end
            if (hit_resp) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

    a_ready_needs_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        cpu_ready |-> cpu_valid
    );

    // memory answers only an open request
    a_ready_needs_read: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_ready |-> mem_read
    );

endmodule

/* verilog/icache_data_store.sv */
`timescale 1ns/1ps

module icache_data_store
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  logic    clk,
    input  index_t  index,
    input  offset_t offset,
    input  logic    fill,
    input  logic    fill_way2,
    input  line_t   fill_line,
    output word_t   word_way1,
    output word_t   word_way2
);

    line_t line_w1 [NUM_SETS];
    line_t line_w2 [NUM_SETS];

    // both ways read in parallel for the controller
    assign word_way1 = line_w1[index][offset*WORD_BITS +: WORD_BITS];
    assign word_way2 = line_w2[index][offset*WORD_BITS +: WORD_BITS];

    // whole line written on the fill cycle
    always_ff @(posedge clk) begin
        if (fill) begin
            if (fill_way2) begin
                line_w2[index] <= fill_line;
            end else begin
                line_w1[index] <= fill_line;
            end
        end
    end

    // memory must present a defined line with mem_ready
    a_fill_known: assert property (
        @(posedge clk)
        fill |-> !$isunknown(fill_line)
    );

endmodule

/* verilog/icache_tag_store.sv */
`timescale 1ns/1ps

module icache_tag_store
    import cache_geom_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  index_t index,
    input  tag_t   lookup_tag,
    input  logic   touch,
    input  logic   fill,
    input  logic   fill_way2,
    output logic   hit_way1,
    output logic   hit_way2,
    output logic   victim_way2
);

    tag_t tag_w1 [NUM_SETS];
    tag_t tag_w2 [NUM_SETS];

    logic [NUM_SETS-1:0] valid_w1;
    logic [NUM_SETS-1:0] valid_w2;
    // set when way 2 was used last
    logic [NUM_SETS-1:0] mru_w2;

    assign hit_way1 = valid_w1[index] && (tag_w1[index] == lookup_tag);
    assign hit_way2 = valid_w2[index] && (tag_w2[index] == lookup_tag);

    // empty way 1, then empty way 2, then the older way
    assign victim_way2 = valid_w1[index] && (!valid_w2[index] || !mru_w2[index]);

    // tag of the filled way
    always_ff @(posedge clk) begin
        if (fill) begin
            if (fill_way2) begin
                tag_w2[index] <= lookup_tag;
            end else begin
                tag_w1[index] <= lookup_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_w1 <= '0;
            valid_w2 <= '0;
            mru_w2   <= '0;
        end else if (fill) begin
            if (fill_way2) begin
                valid_w2[index] <= 1'b1;
            end else begin
                valid_w1[index] <= 1'b1;
            end
            mru_w2[index] <= fill_way2;
        end else if (touch) begin
            mru_w2[index] <= hit_way2;
        end
    end

    // a line is only ever filled on a miss, so one tag lives in at most one way
    a_single_hit: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(hit_way1 && hit_way2)
    );

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   cpu_valid,
    input  word_t  cpu_addr,
    output word_t  cpu_data,
    output logic   cpu_ready,
    output logic   mem_read,
    output word_t  mem_addr,
    input  line_t  mem_line,
    input  logic   mem_ready,
    output count_t hit_count,
    output count_t access_count
);

    // address fields
    tag_t    addr_tag;
    index_t  addr_index;
    offset_t addr_offset;

    logic  hit_way1;
    logic  hit_way2;
    logic  victim_way2;
    logic  touch;
    logic  fill;
    logic  fill_way2;
    word_t word_way1;
    word_t word_way2;

    assign addr_tag    = cpu_addr[WORD_BITS-1 -: TAG_BITS];
    assign addr_index  = cpu_addr[OFFSET_BITS +: INDEX_BITS];
    assign addr_offset = cpu_addr[OFFSET_BITS-1:0];

    icache_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_valid    (cpu_valid),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data),
        .cpu_ready    (cpu_ready),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_line     (mem_line),
        .mem_ready    (mem_ready),
        .hit_way1     (hit_way1),
        .hit_way2     (hit_way2),
        .victim_way2  (victim_way2),
        .touch        (touch),
        .fill         (fill),
        .fill_way2    (fill_way2),
        .word_way1    (word_way1),
        .word_way2    (word_way2),
        .hit_count    (hit_count),
        .access_count (access_count)
    );

    icache_tag_store u_tag_store (
        .clk         (clk),
        .reset_n     (reset_n),
        .index       (addr_index),
        .lookup_tag  (addr_tag),
        .touch       (touch),
        .fill        (fill),
        .fill_way2   (fill_way2),
        .hit_way1    (hit_way1),
        .hit_way2    (hit_way2),
        .victim_way2 (victim_way2)
    );

    // line comes straight from memory
    icache_data_store u_data_store (
        .clk       (clk),
        .index     (addr_index),
        .offset    (addr_offset),
        .fill      (fill),
        .fill_way2 (fill_way2),
        .fill_line (mem_line),
        .word_way1 (word_way1),
        .word_way2 (word_way2)
    );

endmodule

/* verilog/mem_bus_pkg.sv */
package mem_bus_pkg;

    // width of a word and of a word address
    localparam int WORD_BITS = 16;

    // words carried by one memory line transfer
    localparam int LINE_WORDS = 4;

    // cpu data and addresses
    typedef logic [WORD_BITS-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;

endpackage
